// File: hdl/sfm_fp_glob_minmax.sv
`timescale 1ns/1ns

`include "sfm_fp_macros.svh"

module sfm_fp_glob_minmax #(
    parameter int unsigned VECT_WIDTH = 4,
    parameter int unsigned NUM_REGS   = 1
) (
    input  logic                                    clk_i,
    input  logic                                    rst_ni,
    input  logic                                    clear_i,
    input  logic                                    enable_i,
    input  logic                                    valid_i,
    input  logic                                    ready_i,
    input  logic                                    load_en_i,
    input  sfm_pkg::minmax_mode_e                   operation_i,
    input  logic [VECT_WIDTH-1:0]                   strb_i,
    input  sfm_pkg::fp_t [VECT_WIDTH-1:0]           vect_i,
    input  sfm_pkg::fp_t                            load_i,
    output sfm_pkg::fp_t                            cur_minmax_o,
    output sfm_pkg::fp_t                            new_minmax_o,
    output logic                                    new_flg_o,
    output logic                                    valid_o,
    output logic                                    ready_o
);

    sfm_pkg::fp_t identity;
    sfm_pkg::fp_t minmax_q;
    sfm_pkg::fp_t vect_minmax;

    logic minmax_strb;
    logic minmax_valid;
    logic beats_reg;
    logic new_flg;
    logic valid_q;

    assign identity = (operation_i == sfm_pkg::MAX) ? `SFM_NEG_INFTY : `SFM_POS_INFTY;

    sfm_fp_red_minmax #(
        .VECT_WIDTH (VECT_WIDTH),
        .NUM_REGS   (NUM_REGS)
    ) i_reduction (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .clear_i  (clear_i),
        .enable_i (enable_i),
        .valid_i  (valid_i),
        .ready_i  (ready_i),
        .mode_i   (operation_i),
        .strb_i   (strb_i),
        .vect_i   (vect_i),
        .res_o    (vect_minmax),
        .strb_o   (minmax_strb),
        .valid_o  (minmax_valid),
        .ready_o  (ready_o)
    );

    //////////////////////////////
    // global extremum register
    //////////////////////////////

    assign beats_reg = (operation_i == sfm_pkg::MAX) ? `SFM_FP_GT(vect_minmax, minmax_q) :
                                                       `SFM_FP_LT(vect_minmax, minmax_q);

    // an all-masked beat reduces to the identity and never wins
    assign new_flg = minmax_valid & beats_reg;

    // clear over load over update
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            minmax_q <= identity;
        end else if (clear_i) begin
            minmax_q <= identity;
        end else if (load_en_i) begin
            minmax_q <= load_i;
        end else if (new_flg & ready_i) begin
            minmax_q <= vect_minmax;
        end
    end

    // sticky until clear
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (clear_i) begin
            valid_q <= 1'b0;
        end else if (minmax_valid) begin
            valid_q <= 1'b1;
        end
    end

    assign cur_minmax_o = minmax_q;
    assign new_minmax_o = new_flg ? vect_minmax : minmax_q;
    assign new_flg_o    = new_flg;
    assign valid_o      = valid_q;

    assert property (@(posedge clk_i) disable iff (!rst_ni) new_flg_o |-> minmax_strb)
        else $error("improvement flag without strobed lanes");

    assert property (@(posedge clk_i) disable iff (!rst_ni)
                     clear_i |=> cur_minmax_o == $past(identity))
        else $error("register not at identity after clear");

endmodule

// File: hdl/sfm_fp_red_minmax.sv
`timescale 1ns/1ns

`include "sfm_fp_macros.svh"

module sfm_fp_red_minmax #(
    parameter int unsigned VECT_WIDTH = 4,
    parameter int unsigned NUM_REGS   = 1
) (
    input  logic                                    clk_i,
    input  logic                                    rst_ni,
    input  logic                                    clear_i,
    input  logic                                    enable_i,
    input  logic                                    valid_i,
    input  logic                                    ready_i,
    input  sfm_pkg::minmax_mode_e                   mode_i,
    input  logic [VECT_WIDTH-1:0]                   strb_i,
    input  sfm_pkg::fp_t [VECT_WIDTH-1:0]           vect_i,
    output sfm_pkg::fp_t                            res_o,
    output logic                                    strb_o,
    output logic                                    valid_o,
    output logic                                    ready_o
);

    // tree padded to a power of two, heap layout with root at index 0
    localparam int unsigned LEVELS     = $clog2(VECT_WIDTH);
    localparam int unsigned NUM_LEAVES = 1 << LEVELS;
    localparam int unsigned NUM_NODES  = 2 * NUM_LEAVES - 1;

    sfm_pkg::fp_t identity;
    sfm_pkg::fp_t tree [NUM_NODES];

    // index 0 is the tree output, 1..NUM_REGS are the pipeline stages
    sfm_pkg::fp_t res_d   [NUM_REGS+1];
    logic         strb_d  [NUM_REGS+1];
    logic         valid_d [NUM_REGS+1];

    logic advance;

    assign identity = (mode_i == sfm_pkg::MAX) ? `SFM_NEG_INFTY : `SFM_POS_INFTY;

    //////////////////////////////
    // comparison tree
    //////////////////////////////

    for (genvar l = 0; l < NUM_LEAVES; l++) begin : gen_leaf
        if (l < VECT_WIDTH) begin : gen_lane
            // masked lanes never win
            assign tree[NUM_LEAVES-1+l] = strb_i[l] ? vect_i[l] : identity;
        end else begin : gen_pad
            assign tree[NUM_LEAVES-1+l] = identity;
        end
    end

    for (genvar n = 0; n < NUM_LEAVES - 1; n++) begin : gen_node
        logic left_wins;

        assign left_wins = (mode_i == sfm_pkg::MAX) ?
                           `SFM_FP_GT(tree[2*n+1], tree[2*n+2]) :
                           `SFM_FP_LT(tree[2*n+1], tree[2*n+2]);

        assign tree[n] = left_wins ? tree[2*n+1] : tree[2*n+2];
    end

    //////////////////////////////
    // output pipeline
    //////////////////////////////

    assign res_d[0]   = tree[0];
    assign strb_d[0]  = |strb_i;
    assign valid_d[0] = valid_i & enable_i;

    // whole pipeline stalls on back-pressure
    assign advance = enable_i & ready_i;

    for (genvar k = 1; k <= NUM_REGS; k++) begin : gen_stage
        always_ff @(posedge clk_i or negedge rst_ni) begin
            if (!rst_ni) begin
                valid_d[k] <= 1'b0;
            end else if (clear_i) begin
                valid_d[k] <= 1'b0;
            end else if (advance) begin
                valid_d[k] <= valid_d[k-1];
            end
        end

        always_ff @(posedge clk_i) begin
            if (advance) begin
                res_d[k]  <= res_d[k-1];
                strb_d[k] <= strb_d[k-1];
            end
        end
    end

    assign res_o   = res_d[NUM_REGS];
    assign strb_o  = strb_d[NUM_REGS];
    assign valid_o = valid_d[NUM_REGS];
    assign ready_o = ready_i;

    if (NUM_REGS > 0) begin : gen_chk
        // a clear empties every stage on the same edge
        assert property (@(posedge clk_i) disable iff (!rst_ni) clear_i |=> !valid_o)
            else $error("reduction valid high after clear");
    end

endmodule

// File: hdl/sfm_max_top.sv
`timescale 1ns/1ns

module sfm_max_top #(
    parameter int unsigned VECT_WIDTH = 4,
    parameter int unsigned NUM_REGS   = 1
) (
    input  logic                                    clk_i,
    input  logic                                    rst_ni,
    input  logic                                    clear_i,
    input  logic                                    enable_i,
    input  logic                                    valid_i,
    input  logic                                    ready_i,
    input  logic                                    load_en_i,
    input  sfm_pkg::minmax_mode_e                   operation_i,
    input  logic [VECT_WIDTH-1:0]                   strb_i,
    input  sfm_pkg::fp_t [VECT_WIDTH-1:0]           vect_i,
    input  sfm_pkg::fp_t                            load_i,
    output sfm_pkg::fp_t                            cur_minmax_o,
    output sfm_pkg::fp_t                            new_minmax_o,
    output logic                                    new_flg_o,
    output logic                                    valid_o,
    output logic                                    ready_o
);

    sfm_fp_glob_minmax #(
        .VECT_WIDTH (VECT_WIDTH),
        .NUM_REGS   (NUM_REGS)
    ) i_glob_minmax (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .clear_i      (clear_i),
        .enable_i     (enable_i),
        .valid_i      (valid_i),
        .ready_i      (ready_i),
        .load_en_i    (load_en_i),
        .operation_i  (operation_i),
        .strb_i       (strb_i),
        .vect_i       (vect_i),
        .load_i       (load_i),
        .cur_minmax_o (cur_minmax_o),
        .new_minmax_o (new_minmax_o),
        .new_flg_o    (new_flg_o),
        .valid_o      (valid_o),
        .ready_o      (ready_o)
    );

endmodule

// File: hdl/sfm_pkg.sv
package sfm_pkg;

    //////////////////////////////
    // half-precision format
    //////////////////////////////

    localparam int unsigned EXP_BITS = 5;
    localparam int unsigned MAN_BITS = 10;

    // sign + exponent + mantissa
    localparam int unsigned FP_WIDTH = 1 + EXP_BITS + MAN_BITS;

    typedef logic [FP_WIDTH-1:0] fp_t;

    //////////////////////////////
    // operation mode
    //////////////////////////////

    // MAX keeps the largest value, MIN the smallest
    typedef enum logic {
        MAX = 1'b0,
        MIN = 1'b1
    } minmax_mode_e;

endpackage

// File: include/sfm_fp_macros.svh
`ifndef SFM_FP_MACROS_SVH
`define SFM_FP_MACROS_SVH

// half-precision infinities, built from the package format constants
`define SFM_POS_INFTY \
    {1'b0, {sfm_pkg::EXP_BITS{1'b1}}, {sfm_pkg::MAN_BITS{1'b0}}}

`define SFM_NEG_INFTY \
    {1'b1, {sfm_pkg::EXP_BITS{1'b1}}, {sfm_pkg::MAN_BITS{1'b0}}}

// field access, arguments must be plain names or array elements
`define SFM_FP_SIGN(a) a[sfm_pkg::FP_WIDTH-1]
`define SFM_FP_MAG(a) a[sfm_pkg::FP_WIDTH-2:0]
`define SFM_FP_IS_ZERO(a) (`SFM_FP_MAG(a) == '0)

// a > b on raw bit patterns, +0 and -0 compare equal, no NaN handling
`define SFM_FP_GT(a, b) \
    (!(`SFM_FP_IS_ZERO(a) && `SFM_FP_IS_ZERO(b)) && \
     ((`SFM_FP_SIGN(a) != `SFM_FP_SIGN(b)) ? !`SFM_FP_SIGN(a) : \
      (`SFM_FP_SIGN(a) ? (`SFM_FP_MAG(a) < `SFM_FP_MAG(b)) : \
                        (`SFM_FP_MAG(a) > `SFM_FP_MAG(b)))))

// a < b is b > a
`define SFM_FP_LT(a, b) `SFM_FP_GT(b, a)

`endif

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the sfm_max testbench with Verilator
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_sfm_max \
    -f sfm_max.f -o tb_sfm_max
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_sfm_max)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "^Simulation completed successfully$"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: sfm_max.f
+incdir+include
hdl/sfm_pkg.sv
hdl/sfm_fp_red_minmax.sv
hdl/sfm_fp_glob_minmax.sv
hdl/sfm_max_top.sv
sim/tb_sfm_max.sv

// File: sim/tb_sfm_max.sv
`timescale 1ns/1ns

`include "sfm_fp_macros.svh"

module tb_sfm_max;

    localparam int VECT_WIDTH  = 4;
    localparam int NUM_REGS    = 1;
    localparam int RAND_BEATS  = 300;
    localparam int ZERO_BEATS  = 20;
    localparam int LOAD_BEATS  = 100;
    localparam int BP_BEATS    = 200;
    localparam int TOTAL_BEATS = 2 * RAND_BEATS + ZERO_BEATS + LOAD_BEATS + BP_BEATS;
    localparam int CYCLE_LIMIT = 2 * TOTAL_BEATS + 200;

    logic                          clk_i;
    logic                          rst_ni;
    logic                          clear_i;
    logic                          enable_i;
    logic                          valid_i;
    logic                          ready_i;
    logic                          load_en_i;
    sfm_pkg::minmax_mode_e         operation_i;
    logic [VECT_WIDTH-1:0]         strb_i;
    sfm_pkg::fp_t [VECT_WIDTH-1:0] vect_i;
    sfm_pkg::fp_t                  load_i;
    sfm_pkg::fp_t                  cur_minmax_o;
    sfm_pkg::fp_t                  new_minmax_o;
    logic                          new_flg_o;
    logic                          valid_o;
    logic                          ready_o;

    // reference model state
    logic                  q_valid [$];
    logic                  q_strb  [$];
    sfm_pkg::fp_t          q_res   [$];
    sfm_pkg::fp_t          m_reg;
    logic                  m_sticky;
    sfm_pkg::fp_t          run_ext;
    logic                  hold_prev;
    sfm_pkg::fp_t          cur_prev;
    sfm_pkg::minmax_mode_e mode;

    int seed;
    int errors = 0;
    int cycle_cnt = 0;

    sfm_max_top #(.VECT_WIDTH(VECT_WIDTH), .NUM_REGS(NUM_REGS)) UUT (.*);

    always #50 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("errors: %0d", errors);
            $display("Simulation failed");
            $finish;
        end
    end

    //////////////////////////////
    // ordering rule
    //////////////////////////////

    function automatic sfm_pkg::fp_t identity_of(sfm_pkg::minmax_mode_e m);
        return (m == sfm_pkg::MAX) ? `SFM_NEG_INFTY : `SFM_POS_INFTY;
    endfunction

    function automatic logic better(sfm_pkg::fp_t a, sfm_pkg::fp_t b, sfm_pkg::minmax_mode_e m);
        if (m == sfm_pkg::MAX) begin
            return `SFM_FP_GT(a, b);
        end
        return `SFM_FP_LT(a, b);
    endfunction

    // zeros of either sign are the same value
    function automatic logic same_value(sfm_pkg::fp_t a, sfm_pkg::fp_t b);
        return (a == b) || (`SFM_FP_IS_ZERO(a) && `SFM_FP_IS_ZERO(b));
    endfunction

    // linear scan over the strobed lanes
    function automatic sfm_pkg::fp_t reduce_lanes(logic [VECT_WIDTH-1:0] s,
                                                 sfm_pkg::fp_t [VECT_WIDTH-1:0] d,
                                                 sfm_pkg::minmax_mode_e m);
        sfm_pkg::fp_t best;
        best = identity_of(m);
        for (int l = 0; l < VECT_WIDTH; l++) begin
            if (s[l] && better(d[l], best, m)) begin
                best = d[l];
            end
        end
        return best;
    endfunction

    function automatic sfm_pkg::fp_t random_value();
        logic [31:0]  r;
        sfm_pkg::fp_t v;
        r = $random(seed);
        v = r[15:0];
        // no infinity or NaN patterns
        if (v[14:10] == 5'h1f) begin
            v[14] = 1'b0;
        end
        // now and then a zero of either sign
        if (r[31:27] == 5'd0) begin
            v = {r[16], 15'd0};
        end
        return v;
    endfunction

    task automatic mismatch(input string what, input logic [15:0] got, input logic [15:0] exp);
        errors++;
        $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
    endtask

    //////////////////////////////
    // one clock cycle
    //////////////////////////////

    task automatic step(input logic v, input logic rdy, input logic clr, input logic ld,
                        input sfm_pkg::fp_t ld_val, input logic [VECT_WIDTH-1:0] s,
                        input sfm_pkg::fp_t [VECT_WIDTH-1:0] d, output logic accepted);
        logic         out_valid;
        logic         out_strb;
        sfm_pkg::fp_t out_res;
        logic         flg_exp;
        sfm_pkg::fp_t new_exp;
        sfm_pkg::fp_t red;
        @(negedge clk_i);
        valid_i     = v;
        ready_i     = rdy;
        clear_i     = clr;
        load_en_i   = ld;
        load_i      = ld_val;
        strb_i      = s;
        vect_i      = d;
        operation_i = mode;
        #1;
        red = reduce_lanes(s, d, mode);
        if (NUM_REGS == 0) begin
            out_valid = v & enable_i;
            out_strb  = |s;
            out_res   = red;
        end else begin
            out_valid = q_valid[0];
            out_strb  = q_strb[0];
            out_res   = q_res[0];
        end
        flg_exp = out_valid && out_strb && better(out_res, m_reg, mode);
        new_exp = flg_exp ? out_res : m_reg;
        assert (new_flg_o == flg_exp) else mismatch("new_flg_o", 16'(new_flg_o), 16'(flg_exp));
        assert (same_value(new_minmax_o, new_exp))
            else mismatch("new_minmax_o", new_minmax_o, new_exp);
        assert (same_value(cur_minmax_o, m_reg)) else mismatch("cur_minmax_o", cur_minmax_o, m_reg);
        assert (valid_o == m_sticky) else mismatch("valid_o", 16'(valid_o), 16'(m_sticky));
        assert (ready_o == rdy) else mismatch("ready_o", 16'(ready_o), 16'(rdy));
        if (hold_prev) begin
            assert (cur_minmax_o == cur_prev)
                else mismatch("cur_minmax_o under back-pressure", cur_minmax_o, cur_prev);
        end
        hold_prev = !rdy && !clr && !ld;
        cur_prev  = cur_minmax_o;
        // register and sticky valid as of the coming edge
        if (clr) begin
            m_reg = identity_of(mode);
        end else if (ld) begin
            m_reg = ld_val;
        end else if (flg_exp && rdy) begin
            m_reg = out_res;
        end
        if (clr) begin
            m_sticky = 1'b0;
        end else if (out_valid) begin
            m_sticky = 1'b1;
        end
        if (enable_i && rdy) begin
            q_valid.push_back(v & enable_i);
            q_strb.push_back(|s);
            q_res.push_back(red);
            void'(q_valid.pop_front());
            void'(q_strb.pop_front());
            void'(q_res.pop_front());
        end
        if (clr) begin
            foreach (q_valid[i]) q_valid[i] = 1'b0;
        end
        accepted = v && rdy && enable_i && !clr;
        if (clr) begin
            run_ext = identity_of(mode);
        end else if (ld) begin
            run_ext = ld_val;
        end else if (accepted && better(red, run_ext, mode)) begin
            run_ext = red;
        end
    endtask

    task automatic idle(input int n);
        logic acc;
        repeat (n) step(1'b0, 1'b1, 1'b0, 1'b0, '0, '0, '0, acc);
    endtask

    // beats are held until accepted, ready toggles in random stretches when stalling
    task automatic run_beats(input int n, input logic stall);
        logic [VECT_WIDTH-1:0]         s;
        sfm_pkg::fp_t [VECT_WIDTH-1:0] d;
        logic [31:0]                   r;
        logic                          rdy;
        logic                          acc;
        int                            stretch;
        int                            done;
        rdy     = 1'b1;
        acc     = 1'b1;
        stretch = 0;
        done    = 0;
        while (done < n) begin
            if (acc) begin
                r = $random(seed);
                s = r[VECT_WIDTH-1:0];
                for (int l = 0; l < VECT_WIDTH; l++) d[l] = random_value();
            end
            if (stall && stretch == 0) begin
                r       = $random(seed);
                rdy     = r[0];
                stretch = 1 + int'(r[3:1]);
            end
            if (stall) stretch--;
            step(1'b1, rdy, 1'b0, 1'b0, '0, s, d, acc);
            if (acc) done++;
        end
    endtask

    task automatic check_running(input string what);
        idle(NUM_REGS + 2);
        assert (same_value(cur_minmax_o, run_ext)) else mismatch(what, cur_minmax_o, run_ext);
    endtask

    task automatic clear_to(input sfm_pkg::minmax_mode_e m);
        logic acc;
        mode = m;
        step(1'b0, 1'b1, 1'b1, 1'b0, '0, '0, '0, acc);
        idle(1);
        assert (cur_minmax_o == identity_of(mode))
            else mismatch("cur_minmax_o after clear", cur_minmax_o, identity_of(mode));
        assert (!valid_o) else begin
            errors++;
            $display("[FAIL] %0t: valid_o still high after clear", $time);
        end
    endtask

    initial begin
        sfm_pkg::fp_t [VECT_WIDTH-1:0] d;
        sfm_pkg::fp_t                  held;
        sfm_pkg::fp_t                  ld_val;
        logic                          acc;
        clk_i       = 1'b0;
        rst_ni      = 1'b0;
        clear_i     = 1'b0;
        enable_i    = 1'b1;
        valid_i     = 1'b0;
        ready_i     = 1'b1;
        load_en_i   = 1'b0;
        operation_i = sfm_pkg::MAX;
        strb_i      = '0;
        vect_i      = '0;
        load_i      = '0;
        seed        = 32'h7a71;
        mode        = sfm_pkg::MAX;
        m_reg       = identity_of(mode);
        run_ext     = identity_of(mode);
        m_sticky    = 1'b0;
        hold_prev   = 1'b0;
        cur_prev    = '0;
        repeat (NUM_REGS) begin
            q_valid.push_back(1'b0);
            q_strb.push_back(1'b0);
            q_res.push_back('0);
        end
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        #1;
        assert (cur_minmax_o == identity_of(mode) && !valid_o) else begin
            errors++;
            $display("[FAIL] %0t: register not at identity or valid_o high after reset", $time);
        end

        run_beats(RAND_BEATS, 1'b0);
        check_running("running maximum");
        clear_to(sfm_pkg::MIN);
        run_beats(RAND_BEATS, 1'b0);
        check_running("running minimum");

        // all-zero strobes leave the register alone
        held = cur_minmax_o;
        repeat (ZERO_BEATS) begin
            for (int l = 0; l < VECT_WIDTH; l++) d[l] = random_value();
            step(1'b1, 1'b1, 1'b0, 1'b0, '0, '0, d, acc);
            assert (!new_flg_o) else mismatch("new_flg_o on empty strobe", 16'(new_flg_o), 16'd0);
        end
        check_running("extremum after empty strobes");
        assert (cur_minmax_o == held) else mismatch("cur_minmax_o after empty", cur_minmax_o, held);

        clear_to(sfm_pkg::MAX);
        ld_val = random_value();
        ld_val[15] = 1'b0;
        step(1'b0, 1'b1, 1'b0, 1'b1, ld_val, '0, '0, acc);
        idle(1);
        assert (cur_minmax_o == ld_val) else mismatch("cur_minmax_o after load", cur_minmax_o, ld_val);
        run_beats(LOAD_BEATS, 1'b0);
        check_running("maximum after load");

        clear_to(sfm_pkg::MIN);
        run_beats(BP_BEATS, 1'b1);
        check_running("minimum after back-pressure");

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
